//--- lc3b_pipe.f
+incdir+logic
logic/lc3b_isa_pkg.sv
logic/lc3b_pipe_pkg.sv
logic/fetch_ctrl.sv
logic/control_rom.sv
logic/regfile.sv
logic/execute_unit.sv
logic/retire_counter.sv
logic/cpu_datapath.sv
tests/cpu_datapath_tb.sv

//--- logic/control_rom.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode ROM. Turns an instruction word into the control word
// carried down the pipe. Unsupported opcodes become no-ops.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module control_rom (
	input  lc3b_isa_pkg::lc3b_word           i_ir,
	output lc3b_pipe_pkg::lc3b_control_word  o_ctrl
);

	lc3b_isa_pkg::lc3b_opcode opcode;

	assign opcode = lc3b_isa_pkg::lc3b_opcode'(i_ir[15:12]);

	always_comb begin
		// Default is a no-op that still retires
		o_ctrl = '0;
		o_ctrl.aluop = lc3b_pipe_pkg::alu_pass;
		case (opcode)
			lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and: begin
				o_ctrl.aluop = (opcode == lc3b_isa_pkg::op_add) ?
					lc3b_pipe_pkg::alu_add : lc3b_pipe_pkg::alu_and;
				o_ctrl.sr2mux_sel = i_ir[5];
				o_ctrl.load_reg = 1'b1;
				o_ctrl.load_cc = 1'b1;
			end
			lc3b_isa_pkg::op_not: begin
				o_ctrl.aluop = lc3b_pipe_pkg::alu_not;
				o_ctrl.load_reg = 1'b1;
				o_ctrl.load_cc = 1'b1;
			end
			lc3b_isa_pkg::op_lea: begin
				o_ctrl.addr_sel = 1'b1;
				o_ctrl.load_reg = 1'b1;
			end
			lc3b_isa_pkg::op_br: o_ctrl.is_br = 1'b1;
			default: ;
		endcase
	end

endmodule : control_rom

//--- logic/cpu_datapath.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Three-stage LC-3b core: fetch, decode, execute/writeback.
// Connect an instruction memory with read level and response
// strobe; o_wb shows each retiring instruction.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module cpu_datapath (
	input  logic                      clk,
	input  logic                      i_rst,
	output lc3b_isa_pkg::lc3b_word    o_imem_addr,
	output logic                      o_imem_read,
	input  logic                      i_imem_resp,
	input  lc3b_isa_pkg::lc3b_word    i_imem_rdata,
	output lc3b_pipe_pkg::lc3b_wb     o_wb,
	output logic [`LC3B_RETIRE_W-1:0] o_retired
);

	// Fetch to decode
	lc3b_pipe_pkg::lc3b_if_id if_id;
	// Decode
	lc3b_pipe_pkg::lc3b_control_word control_store;
	lc3b_isa_pkg::lc3b_word sr1_out;
	lc3b_isa_pkg::lc3b_word sr2_out;
	lc3b_isa_pkg::lc3b_cc cc_out;
	// Decode to execute
	lc3b_pipe_pkg::lc3b_id_ex id_ex, id_ex_next;
	// Execute
	lc3b_pipe_pkg::lc3b_wb wb;
	lc3b_pipe_pkg::lc3b_redirect redirect;
	logic load_cc;

	fetch_ctrl fetch_ctrl_i (
		.clk,
		.i_rst,
		.i_imem_resp,
		.i_imem_rdata,
		.i_redirect(redirect),
		.o_imem_addr,
		.o_imem_read,
		.o_if_id(if_id)
	);

	control_rom control_rom_i (
		.i_ir(if_id.ir),
		.o_ctrl(control_store)
	);

	regfile regfile_i (
		.clk,
		.i_rst,
		.i_src_a(if_id.ir[8:6]),
		.i_src_b(if_id.ir[2:0]),
		.i_wb(wb),
		.i_load_cc(load_cc),
		.o_reg_a(sr1_out),
		.o_reg_b(sr2_out),
		.o_cc(cc_out)
	);

	// Taken branch in execute kills whatever sits in decode
	always_comb begin
		id_ex_next.valid = if_id.valid && !redirect.taken;
		id_ex_next.pc_plus2 = if_id.pc_plus2;
		id_ex_next.ir = if_id.ir;
		id_ex_next.sr1 = sr1_out;
		id_ex_next.sr2 = sr2_out;
		id_ex_next.dest = if_id.ir[11:9];
		id_ex_next.ctrl = control_store;
	end

	// Execute never waits, so no load enable
	always_ff @(posedge clk) begin
		id_ex <= id_ex_next;
		if (i_rst)
			id_ex.valid <= 1'b0;
	end

	execute_unit execute_unit_i (
		.i_id_ex(id_ex),
		.i_cc(cc_out),
		.o_wb(wb),
		.o_load_cc(load_cc),
		.o_redirect(redirect)
	);

	retire_counter retire_counter_i (
		.clk,
		.i_rst,
		.i_retire(wb.valid),
		.o_count(o_retired)
	);

	assign o_wb = wb;

endmodule : cpu_datapath

//--- logic/execute_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute/writeback stage. ALU, PC-relative address adder and
// branch test; produces the retirement record and redirect.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module execute_unit (
	input  lc3b_pipe_pkg::lc3b_id_ex    i_id_ex,
	input  lc3b_isa_pkg::lc3b_cc        i_cc,
	output lc3b_pipe_pkg::lc3b_wb       o_wb,
	output logic                        o_load_cc,
	output lc3b_pipe_pkg::lc3b_redirect o_redirect
);

	lc3b_isa_pkg::lc3b_word ir;
	lc3b_isa_pkg::lc3b_word sext5;
	lc3b_isa_pkg::lc3b_word off9_shl;
	lc3b_isa_pkg::lc3b_word sr2mux_out;
	lc3b_isa_pkg::lc3b_word alu_out;
	lc3b_isa_pkg::lc3b_word addr_out;
	lc3b_isa_pkg::lc3b_reg nzp;
	lc3b_pipe_pkg::lc3b_control_word ctrl;

	assign ir = i_id_ex.ir;
	assign ctrl = i_id_ex.ctrl;
	assign nzp = ir[11:9];

	assign sext5 = {{(`LC3B_WORD_W-5){ir[4]}}, ir[4:0]};
	// Word offset scaled to bytes
	assign off9_shl = {{(`LC3B_WORD_W-10){ir[8]}}, ir[8:0], 1'b0};

	assign sr2mux_out = ctrl.sr2mux_sel ? sext5 : i_id_ex.sr2;

	always_comb begin
		case (ctrl.aluop)
			lc3b_pipe_pkg::alu_add: alu_out = i_id_ex.sr1 + sr2mux_out;
			lc3b_pipe_pkg::alu_and: alu_out = i_id_ex.sr1 & sr2mux_out;
			lc3b_pipe_pkg::alu_not: alu_out = ~i_id_ex.sr1;
			default: alu_out = i_id_ex.sr1;
		endcase
	end

	assign addr_out = i_id_ex.pc_plus2 + off9_shl;

	always_comb begin
		o_wb.valid = i_id_ex.valid;
		o_wb.dest = i_id_ex.dest;
		o_wb.data = ctrl.addr_sel ? addr_out : alu_out;
		o_wb.load_reg = ctrl.load_reg;
	end

	assign o_load_cc = i_id_ex.valid && ctrl.load_cc;

	// cc here already holds the result of the previous instruction
	assign o_redirect.taken = i_id_ex.valid && ctrl.is_br && |(nzp & i_cc);
	assign o_redirect.target = addr_out;

endmodule : execute_unit

//--- logic/fetch_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch FSM. Owns the PC, holds the instruction memory read
// level until the response strobe and fills the IF/ID register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module fetch_ctrl (
	input  logic                        clk,
	input  logic                        i_rst,
	input  logic                        i_imem_resp,
	input  lc3b_isa_pkg::lc3b_word      i_imem_rdata,
	input  lc3b_pipe_pkg::lc3b_redirect i_redirect,
	output lc3b_isa_pkg::lc3b_word      o_imem_addr,
	output logic                        o_imem_read,
	output lc3b_pipe_pkg::lc3b_if_id    o_if_id
);

	lc3b_pipe_pkg::fetch_state state, state_next;
	lc3b_isa_pkg::lc3b_word pc, pc_next, pc_plus2;
	lc3b_pipe_pkg::lc3b_if_id if_id_next;

	assign pc_plus2 = pc + lc3b_isa_pkg::lc3b_word'(2);
	assign o_imem_addr = pc;
	assign o_imem_read = (state == lc3b_pipe_pkg::S_FETCH);

	always_comb begin
		state_next = state;
		pc_next = pc;
		case (state)
			lc3b_pipe_pkg::S_IDLE: state_next = lc3b_pipe_pkg::S_FETCH;
			lc3b_pipe_pkg::S_FETCH: begin
				if (i_imem_resp)
					pc_next = pc_plus2;
			end
			lc3b_pipe_pkg::S_REDIRECT: state_next = lc3b_pipe_pkg::S_FETCH;
			default: state_next = lc3b_pipe_pkg::S_IDLE;
		endcase
		// Branch from execute wins over everything
		if (i_redirect.taken) begin
			state_next = lc3b_pipe_pkg::S_REDIRECT;
			pc_next = i_redirect.target;
		end
	end

	// Response in the redirect cycle belongs to the wrong path
	always_comb begin
		if_id_next.valid = o_imem_read && i_imem_resp && !i_redirect.taken;
		if_id_next.pc_plus2 = pc_plus2;
		if_id_next.ir = i_imem_rdata;
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state <= lc3b_pipe_pkg::S_IDLE;
			pc <= `LC3B_RESET_PC;
		end else begin
			state <= state_next;
			pc <= pc_next;
		end
	end

	always_ff @(posedge clk) begin
		o_if_id <= if_id_next;
		if (i_rst)
			o_if_id.valid <= 1'b0;
	end

	a_addr_stable: assert property (@(posedge clk) disable iff (i_rst)
		(o_imem_read && !i_imem_resp) |=> (!o_imem_read || $stable(o_imem_addr)));

	// One dead cycle, then the target goes out
	a_redirect_gap: assert property (@(posedge clk) disable iff (i_rst)
		i_redirect.taken |=> (state == lc3b_pipe_pkg::S_REDIRECT && !o_imem_read)
			##1 (o_imem_read && o_imem_addr == $past(i_redirect.target, 2)));

endmodule : fetch_ctrl

//--- logic/lc3b_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Global sizing and reset values for the LC-3b pipeline.
// Include wherever a width or the boot address is needed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// Data and address word
`define LC3B_WORD_W 16

// First fetch address after reset
`define LC3B_RESET_PC 16'h0000

// Width of the retired-instruction count
`define LC3B_RETIRE_W 16

`endif

//--- logic/lc3b_isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Architectural types of the LC-3b instruction set.
// Referenced by scoped name from every RTL file.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "lc3b_cfg.svh"

package lc3b_isa_pkg;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;

	// Register index, also the nzp field of BR
	typedef logic [2:0] lc3b_reg;

	// Condition codes as {n, z, p}
	typedef logic [2:0] lc3b_cc;

	// Opcode field ir[15:12]
	typedef enum logic [3:0] {
		op_br  = 4'b0000, op_add = 4'b0001, op_ldb = 4'b0010, op_stb  = 4'b0011,
		op_jsr = 4'b0100, op_and = 4'b0101, op_ldr = 4'b0110, op_str  = 4'b0111,
		op_rti = 4'b1000, op_not = 4'b1001, op_ldi = 4'b1010, op_sti  = 4'b1011,
		op_jmp = 4'b1100, op_shf = 4'b1101, op_lea = 4'b1110, op_trap = 4'b1111
	} lc3b_opcode;

endpackage : lc3b_isa_pkg

//--- logic/lc3b_pipe_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline-side types: control word, stage registers,
// retirement record, redirect request and fetch FSM states.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lc3b_pipe_pkg;

	typedef enum logic [1:0] {
		alu_pass,
		alu_add,
		alu_and,
		alu_not
	} lc3b_aluop;

	typedef struct packed {
		lc3b_aluop aluop;
		logic sr2mux_sel;   // imm5 instead of SR2
		logic addr_sel;     // write the address adder (LEA)
		logic load_reg;
		logic load_cc;
		logic is_br;
	} lc3b_control_word;

	typedef struct packed {
		logic valid;
		lc3b_isa_pkg::lc3b_word pc_plus2;
		lc3b_isa_pkg::lc3b_word ir;
	} lc3b_if_id;

	typedef struct packed {
		logic valid;
		lc3b_isa_pkg::lc3b_word pc_plus2;
		lc3b_isa_pkg::lc3b_word ir;
		lc3b_isa_pkg::lc3b_word sr1;
		lc3b_isa_pkg::lc3b_word sr2;
		lc3b_isa_pkg::lc3b_reg dest;
		lc3b_control_word ctrl;
	} lc3b_id_ex;

	// One record per instruction leaving execute
	typedef struct packed {
		logic valid;
		lc3b_isa_pkg::lc3b_reg dest;
		lc3b_isa_pkg::lc3b_word data;
		logic load_reg;
	} lc3b_wb;

	typedef struct packed {
		logic taken;
		lc3b_isa_pkg::lc3b_word target;
	} lc3b_redirect;

	typedef enum logic [1:0] {
		S_IDLE,
		S_FETCH,
		S_REDIRECT
	} fetch_state;

endpackage : lc3b_pipe_pkg

//--- logic/regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Eight general registers plus the n/z/p register. Writes land
// at the end of execute; decode reads see them by bypass.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module regfile (
	input  logic                   clk,
	input  logic                   i_rst,
	input  lc3b_isa_pkg::lc3b_reg  i_src_a,
	input  lc3b_isa_pkg::lc3b_reg  i_src_b,
	input  lc3b_pipe_pkg::lc3b_wb  i_wb,
	input  logic                   i_load_cc,
	output lc3b_isa_pkg::lc3b_word o_reg_a,
	output lc3b_isa_pkg::lc3b_word o_reg_b,
	output lc3b_isa_pkg::lc3b_cc   o_cc
);

	lc3b_isa_pkg::lc3b_word regs [8];
	lc3b_isa_pkg::lc3b_cc cc_next;
	logic wr_en;

	assign wr_en = i_wb.valid && i_wb.load_reg;

	always_comb begin
		if (i_wb.data[`LC3B_WORD_W-1])
			cc_next = 3'b100;
		else if (i_wb.data == '0)
			cc_next = 3'b010;
		else
			cc_next = 3'b001;
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
			o_cc <= 3'b010;  // all registers are zero
		end else begin
			if (wr_en)
				regs[i_wb.dest] <= i_wb.data;
			if (i_load_cc)
				o_cc <= cc_next;
		end
	end

	assign o_reg_a = (wr_en && i_wb.dest == i_src_a) ? i_wb.data : regs[i_src_a];
	assign o_reg_b = (wr_en && i_wb.dest == i_src_b) ? i_wb.data : regs[i_src_b];

	a_dest_known: assert property (@(posedge clk) disable iff (i_rst)
		wr_en |-> !$isunknown(i_wb.dest));

endmodule : regfile

//--- logic/retire_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Counts instructions leaving execute, no-ops and branches too.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module retire_counter (
	input  logic                      clk,
	input  logic                      i_rst,
	input  logic                      i_retire,
	output logic [`LC3B_RETIRE_W-1:0] o_count
);

	// Wraps silently at full width
	always_ff @(posedge clk) begin
		if (i_rst)
			o_count <= '0;
		else if (i_retire)
			o_count <= o_count + `LC3B_RETIRE_W'(1);
	end

endmodule : retire_counter

//--- run_sim.sh
#!/usr/bin/env bash
# Build the LC-3b pipeline testbench with Verilator and run it.
# Exits non-zero unless the simulation prints the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f lc3b_pipe.f \
	--top-module cpu_datapath_tb -o cpu_datapath_sim \
	&& ./obj_dir/cpu_datapath_sim | tee /dev/stderr | grep -Fx "all tests passed" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- tests/cpu_datapath_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the three-stage LC-3b core. Runs a random
// program from a variable-latency instruction memory and checks
// every retirement and fetch against an ISA reference model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module cpu_datapath_tb;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int PROG_LEN = 48;
	// A few trailing no-ops past the program
	localparam logic [15:0] END_PC = 16'(2 * PROG_LEN + 8);
	localparam int WATCHDOG_NS = (RESET_CYCLES + PROG_LEN * 8) * CLK_PERIOD + 800;

	logic clk = 1'b0;
	logic i_rst = 1'b1;
	logic i_imem_resp = 1'b0;
	lc3b_isa_pkg::lc3b_word i_imem_rdata = '0;
	lc3b_isa_pkg::lc3b_word o_imem_addr;
	logic o_imem_read;
	lc3b_pipe_pkg::lc3b_wb o_wb;
	logic [`LC3B_RETIRE_W-1:0] o_retired;

	logic [31:0] rng_state = 32'h7e17_59f6;
	lc3b_isa_pkg::lc3b_word prog [64];
	int errors = 0;
	logic started = 1'b0;
	logic seen_read;
	logic [1:0] wait_left;
	lc3b_isa_pkg::lc3b_word mem_addr;
	lc3b_isa_pkg::lc3b_word exp_fetch;

	// Reference model state
	lc3b_isa_pkg::lc3b_word m_pc;
	lc3b_isa_pkg::lc3b_word m_regs [8];
	lc3b_isa_pkg::lc3b_cc m_cc;
	logic [`LC3B_RETIRE_W-1:0] m_retired;
	lc3b_isa_pkg::lc3b_word exp_data;
	lc3b_isa_pkg::lc3b_word exp_next_pc;
	lc3b_isa_pkg::lc3b_reg exp_dest;
	logic exp_load;
	logic exp_cc_load;
	logic exp_taken;
	logic model_taken;

	cpu_datapath cpu_datapath_i (
		.clk,
		.i_rst,
		.o_imem_addr,
		.o_imem_read,
		.i_imem_resp,
		.i_imem_rdata,
		.o_wb,
		.o_retired
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [15:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state[31:16];
	endfunction

	// Past the program the memory reads as BR with nzp clear
	function automatic lc3b_isa_pkg::lc3b_word mem_word(input lc3b_isa_pkg::lc3b_word addr);
		if (addr[15:1] < 15'(PROG_LEN))
			return prog[addr[6:1]];
		return 16'h0000;
	endfunction

	function automatic lc3b_isa_pkg::lc3b_cc flags_of(input lc3b_isa_pkg::lc3b_word value);
		if (value[`LC3B_WORD_W-1])
			return 3'b100;
		if (value == '0)
			return 3'b010;
		return 3'b001;
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("[FAIL] %t %s", $realtime, msg);
	endtask

	task automatic report_protocol(input string msg);
		errors++;
		$display("Protocol error at %t: %s", $realtime, msg);
	endtask

	task automatic build_program();
		lc3b_isa_pkg::lc3b_word a;
		lc3b_isa_pkg::lc3b_word b;
		lc3b_isa_pkg::lc3b_reg dr;
		lc3b_isa_pkg::lc3b_reg sr1;
		lc3b_isa_pkg::lc3b_reg prev_dr;
		prev_dr = 3'd0;
		for (int i = 0; i < 64; i++)
			prog[6'(i)] = 16'h0000;
		for (int i = 0; i < PROG_LEN; i++) begin
			a = next_rand();
			b = next_rand();
			dr = a[2:0];
			// Half the time read the last destination to force hazards
			sr1 = a[15] ? prev_dr : a[5:3];
			case (a % 16'd7)
				16'd0: prog[6'(i)] = {4'h1, dr, sr1, 3'b000, a[8:6]};
				16'd1: prog[6'(i)] = {4'h1, dr, sr1, 1'b1, b[4:0]};
				16'd2: prog[6'(i)] = {4'h5, dr, sr1, 3'b000, a[8:6]};
				16'd3: prog[6'(i)] = {4'h5, dr, sr1, 1'b1, b[4:0]};
				16'd4: prog[6'(i)] = {4'h9, dr, sr1, 6'h3f};
				16'd5: prog[6'(i)] = {4'he, dr, b[13:5]};
				// Forward branch of 0 to 3 words
				default: prog[6'(i)] = {4'h0, a[11:9], 7'd0, b[1:0]};
			endcase
			prev_dr = dr;
		end
	endtask

	initial begin
		$timeformat(-9, 1, " ns", 0);
		build_program();
		repeat (RESET_CYCLES) @(posedge clk);
		i_rst <= 1'b0;
		wait (m_pc >= END_PC);
		repeat (4) @(posedge clk);
		$display("Retired %0d instructions with %0d errors", m_retired, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		#WATCHDOG_NS;
		$display("Watchdog expired before the program ran to its end");
		$display("tests failed");
		$finish;
	end

	always @(posedge clk)
		started <= 1'b1;

	always @(posedge clk) begin
		if (i_rst)
			seen_read <= 1'b0;
		else if (o_imem_read)
			seen_read <= 1'b1;
	end

	// Instruction memory answers after 0 to 3 extra cycles
	always @(posedge clk) begin
		logic [1:0] wait_next;
		lc3b_isa_pkg::lc3b_word addr_next;
		wait_next = wait_left;
		addr_next = mem_addr;
		if (i_rst) begin
			wait_next = 2'd0;
			addr_next = `LC3B_RESET_PC;
		end else if (!o_imem_read || i_imem_resp) begin
			// Next cycle opens a fresh request
			wait_next = 2'(next_rand());
			addr_next = o_imem_read ? o_imem_addr + 16'd2 : o_imem_addr;
		end else if (wait_left != 2'd0) begin
			wait_next = wait_left - 2'd1;
		end
		wait_left <= wait_next;
		mem_addr <= addr_next;
		i_imem_resp <= !i_rst && wait_next == 2'd0;
		i_imem_rdata <= mem_word(addr_next);
	end

	// ISA result of the instruction the model expects to retire next
	always_comb begin
		lc3b_isa_pkg::lc3b_word ir;
		lc3b_isa_pkg::lc3b_word pc2;
		lc3b_isa_pkg::lc3b_word src_b;
		lc3b_isa_pkg::lc3b_word offset;
		ir = mem_word(m_pc);
		pc2 = m_pc + 16'd2;
		src_b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : m_regs[ir[2:0]];
		offset = {{6{ir[8]}}, ir[8:0], 1'b0};
		exp_dest = ir[11:9];
		exp_data = '0;
		exp_taken = 1'b0;
		case (ir[15:12])
			4'h1: exp_data = m_regs[ir[8:6]] + src_b;
			4'h5: exp_data = m_regs[ir[8:6]] & src_b;
			4'h9: exp_data = ~m_regs[ir[8:6]];
			4'he: exp_data = pc2 + offset;
			4'h0: exp_taken = |(ir[11:9] & m_cc);
			default: ;
		endcase
		exp_load = ir[15:12] inside {4'h1, 4'h5, 4'h9, 4'he};
		exp_cc_load = ir[15:12] inside {4'h1, 4'h5, 4'h9};
		exp_next_pc = exp_taken ? pc2 + offset : pc2;
	end

	assign model_taken = o_wb.valid && exp_taken;

	always @(posedge clk) begin
		if (i_rst) begin
			m_pc <= `LC3B_RESET_PC;
			m_cc <= 3'b010;
			m_retired <= '0;
			for (int i = 0; i < 8; i++)
				m_regs[3'(i)] <= '0;
		end else if (o_wb.valid) begin
			m_pc <= exp_next_pc;
			m_retired <= m_retired + `LC3B_RETIRE_W'(1);
			if (exp_load)
				m_regs[exp_dest] <= exp_data;
			if (exp_cc_load)
				m_cc <= flags_of(exp_data);
		end
	end

	// Next address fetch should accept; a taken branch overrides
	always @(posedge clk) begin
		if (i_rst)
			exp_fetch <= `LC3B_RESET_PC;
		else if (model_taken)
			exp_fetch <= exp_next_pc;
		else if (o_imem_read && i_imem_resp)
			exp_fetch <= exp_fetch + 16'd2;
	end

	a_reset_quiet: assert property (@(posedge clk)
		(started && (i_rst || $past(i_rst))) |->
			(!o_imem_read && !o_wb.valid && o_retired == '0))
		else report_protocol("core was active during reset or the cycle after it");

	a_first_addr: assert property (@(posedge clk) disable iff (i_rst)
		(o_imem_read && !seen_read) |-> o_imem_addr == `LC3B_RESET_PC)
		else report_mismatch("first fetch address is not the reset PC");

	a_fetch_addr: assert property (@(posedge clk) disable iff (i_rst)
		(o_imem_read && i_imem_resp) |-> o_imem_addr == exp_fetch)
		else report_mismatch("accepted fetch address differs from the model next PC");

	a_addr_held: assert property (@(posedge clk) disable iff (i_rst)
		(o_imem_read && i_imem_resp) |-> o_imem_addr == mem_addr)
		else report_protocol("fetch address changed while its request was pending");

	a_wb_record: assert property (@(posedge clk) disable iff (i_rst)
		o_wb.valid |-> (o_wb.load_reg == exp_load &&
			(!exp_load || (o_wb.dest == exp_dest && o_wb.data == exp_data))))
		else report_mismatch("retirement record does not match the reference model");

	a_retire_count: assert property (@(posedge clk) disable iff (i_rst)
		o_wb.valid |=> o_retired == m_retired)
		else report_mismatch("retire count differs from the model count");

	a_redirect_gap: assert property (@(posedge clk) disable iff (i_rst)
		model_taken |-> o_imem_read ##1 !o_imem_read
			##1 (o_imem_read && o_imem_addr == $past(exp_next_pc, 2)))
		else report_protocol("fetch did not pause one cycle and restart at the branch target");

	a_squash: assert property (@(posedge clk) disable iff (i_rst)
		model_taken |=> !o_wb.valid ##1 !o_wb.valid ##1 !o_wb.valid)
		else report_protocol("a wrong-path instruction retired after a taken branch");

endmodule : cpu_datapath_tb
